/* logic/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define DATA_W     32   // Machine word
`define REG_AW     5    // 32 architectural registers
`define DMEM_DEPTH 16   // Data words, addr[5:2]

// Opcodes
`define OP_RTYPE 6'b000000
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LOAD  6'b100???  // Any 100xxx
`define OP_STORE 6'b101???  // Any 101xxx

// R-type funct field
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010

// Decoder aluop codes
`define ALUOP_MEM   6'b000000
`define ALUOP_RTYPE 6'b000010
`define ALUOP_ADDI  6'b000011
`define ALUOP_ANDI  6'b000111
`define ALUOP_ORI   6'b001011
`define ALUOP_XORI  6'b001111
`define ALUOP_SLTI  6'b011011

`endif

/* logic/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

  // Decoder outputs, one bit per control plus aluop
  typedef struct packed {
    logic       regdst;    // rd vs rt destination
    logic       regwrite;
    logic       alusrc;    // Immediate as ALU operand b
    logic       memread;
    logic       memwrite;
    logic       memtoreg;  // Load data to writeback
    logic [5:0] aluop;
  } ctrl_t;

  // Bundle handed from decode to execute
  typedef struct packed {
    ctrl_t               ctrl;
    logic [`DATA_W-1:0]  a;      // rs value
    logic [`DATA_W-1:0]  b;      // rt value, also store data
    logic [`DATA_W-1:0]  imm;    // Extended immediate
    logic [`REG_AW-1:0]  dst;
    logic [5:0]          funct;
  } dec_t;

  // Register file write request
  typedef struct packed {
    logic               regwrite;
    logic [`REG_AW-1:0] dst;
    logic [`DATA_W-1:0] data;
  } wb_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT
  } alu_op_e;

endpackage

/* logic/main_control.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module main_control import core_pkg::*; (
  input  logic [5:0] i_opcode,
  output ctrl_t      o_ctrl
);

  always_comb begin
    o_ctrl = '0;  // Unknown opcodes stay all-zero, no side effects

    casez (i_opcode)
      `OP_RTYPE: begin
        o_ctrl.regdst   = 1'b1;  // Result goes to rd
        o_ctrl.regwrite = 1'b1;
        o_ctrl.aluop    = `ALUOP_RTYPE;  // Operation comes from funct
      end
      `OP_ADDI,
      `OP_ADDIU: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = `ALUOP_ADDI;  // Both wrap, no overflow trap
      end
      `OP_ANDI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = `ALUOP_ANDI;
      end
      `OP_ORI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = `ALUOP_ORI;
      end
      `OP_XORI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = `ALUOP_XORI;
      end
      `OP_SLTI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = `ALUOP_SLTI;  // Signed compare against imm
      end
      // Word load, base plus offset
      `OP_LOAD: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memread  = 1'b1;
        o_ctrl.memtoreg = 1'b1;
        o_ctrl.aluop    = `ALUOP_MEM;
      end
      // Word store, no register write
      `OP_STORE: begin
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memwrite = 1'b1;
        o_ctrl.memtoreg = 1'b1;  // Don't care, regwrite is low
        o_ctrl.aluop    = `ALUOP_MEM;
      end
      default: o_ctrl = '0;
    endcase
  end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module decode_stage import core_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_instr_valid,
  input  logic [`DATA_W-1:0] i_instr,
  input  logic               i_wb_valid,
  input  wb_t                i_wb,
  output logic               o_dec_valid,
  output dec_t               o_dec
);

  logic [5:0]         opcode;
  logic [`REG_AW-1:0] rs, rt, rd;
  logic [15:0]        imm16;
  logic               zext;       // Logic immediates zero-extend
  logic               wb_we;
  logic [`DATA_W-1:0] rs_val, rt_val;
  logic [`DATA_W-1:0] regs [2**`REG_AW];
  ctrl_t              ctrl;

  assign opcode = i_instr[31:26];
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign imm16  = i_instr[15:0];

  assign zext = (opcode == `OP_ANDI) || (opcode == `OP_ORI) || (opcode == `OP_XORI);

  main_control u_main_control (
    .i_opcode (opcode),
    .o_ctrl   (ctrl)
  );

  // Register 0 is never written
  assign wb_we = i_wb_valid && i_wb.regwrite && (i_wb.dst != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 2**`REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[i_wb.dst] <= i_wb.data;
    end
  end

  // Write-before-read: same-cycle write bypasses the array
  assign rs_val = (rs == '0)                  ? '0        :
                  (wb_we && i_wb.dst == rs)   ? i_wb.data : regs[rs];
  assign rt_val = (rt == '0)                  ? '0        :
                  (wb_we && i_wb.dst == rt)   ? i_wb.data : regs[rt];

  always_comb begin
    o_dec.ctrl  = ctrl;
    o_dec.a     = rs_val;
    o_dec.b     = rt_val;
    o_dec.imm   = zext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    o_dec.dst   = ctrl.regdst ? rd : rt;  // R-type writes rd
    o_dec.funct = i_instr[5:0];
  end

  assign o_dec_valid = i_instr_valid;  // Strobe passes straight through

endmodule

/* logic/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_valid,
  output payload_t o_data
);

  // Payload loads every cycle, valid marks it
  always_ff @(posedge i_clk) begin
    o_data <= i_data;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module exec_stage import core_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  dec_t               i_dec,
  output logic               o_wb_valid,
  output wb_t                o_wb,
  output logic               o_st_valid,
  output logic [`DATA_W-1:0] o_st_addr,
  output logic [`DATA_W-1:0] o_st_data
);

  localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

  alu_op_e              alu_op;
  logic [`DATA_W-1:0]   alu_b;
  logic [`DATA_W-1:0]   alu_res;
  logic [`DATA_W-1:0]   ld_data;
  logic [DMEM_AW-1:0]   dmem_idx;
  logic                 st_we;
  logic [`DATA_W-1:0]   dmem [`DMEM_DEPTH];

  // ALU control from aluop and funct
  always_comb begin
    case (i_dec.ctrl.aluop)
      `ALUOP_RTYPE: begin
        case (i_dec.funct)
          `FN_ADD, `FN_ADDU: alu_op = ALU_ADD;
          `FN_SUB:           alu_op = ALU_SUB;
          `FN_AND:           alu_op = ALU_AND;
          `FN_OR:            alu_op = ALU_OR;
          `FN_XOR:           alu_op = ALU_XOR;
          `FN_NOR:           alu_op = ALU_NOR;
          `FN_SLT:           alu_op = ALU_SLT;
          default:           alu_op = ALU_ADD;
        endcase
      end
      `ALUOP_ANDI: alu_op = ALU_AND;
      `ALUOP_ORI:  alu_op = ALU_OR;
      `ALUOP_XORI: alu_op = ALU_XOR;
      `ALUOP_SLTI: alu_op = ALU_SLT;
      default:     alu_op = ALU_ADD;  // Mem address and addi/addiu
    endcase
  end

  assign alu_b = i_dec.ctrl.alusrc ? i_dec.imm : i_dec.b;

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_res = i_dec.a + alu_b;  // Wraps
      ALU_SUB: alu_res = i_dec.a - alu_b;
      ALU_AND: alu_res = i_dec.a & alu_b;
      ALU_OR:  alu_res = i_dec.a | alu_b;
      ALU_XOR: alu_res = i_dec.a ^ alu_b;
      ALU_NOR: alu_res = ~(i_dec.a | alu_b);
      ALU_SLT: alu_res = {{(`DATA_W-1){1'b0}}, $signed(i_dec.a) < $signed(alu_b)};
      default: alu_res = '0;
    endcase
  end

  // Word index, byte offset bits ignored
  assign dmem_idx = alu_res[DMEM_AW+1:2];
  assign st_we    = i_valid && i_dec.ctrl.memwrite;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (st_we) begin
      dmem[dmem_idx] <= i_dec.b;  // Store data is rt
    end
  end

  assign ld_data = i_dec.ctrl.memread ? dmem[dmem_idx] : '0;  // Async read

  // Store is reported in the cycle the memory writes
  assign o_st_valid = st_we;
  assign o_st_addr  = alu_res;
  assign o_st_data  = i_dec.b;

  always_comb begin
    o_wb.regwrite = i_dec.ctrl.regwrite && (i_dec.dst != '0);  // r0 writes dropped
    o_wb.dst      = i_dec.dst;
    o_wb.data     = i_dec.ctrl.memtoreg ? ld_data : alu_res;
  end

  assign o_wb_valid = i_valid && o_wb.regwrite;

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module mips_core import core_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_instr_valid,
  input  logic [`DATA_W-1:0] i_instr,
  output logic               o_res_valid,
  output logic [`REG_AW-1:0] o_res_reg,
  output logic [`DATA_W-1:0] o_res_data,
  output logic               o_st_valid,
  output logic [`DATA_W-1:0] o_st_addr,
  output logic [`DATA_W-1:0] o_st_data
);

  logic dec_valid, ex_valid, wb_valid, wr_valid;
  dec_t dec, ex_dec;
  wb_t  wb, wr;

  decode_stage u_decode (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_wb_valid    (wr_valid),  // Write port fed from EX/WB
    .i_wb          (wr),
    .o_dec_valid   (dec_valid),
    .o_dec         (dec)
  );

  // ID/EX
  pipe_stage #(.payload_t(dec_t)) u_id_ex (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_valid (dec_valid), .i_data (dec),
    .o_valid (ex_valid), .o_data (ex_dec)
  );

  exec_stage u_exec (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (ex_valid),
    .i_dec      (ex_dec),
    .o_wb_valid (wb_valid),
    .o_wb       (wb),
    .o_st_valid (o_st_valid),
    .o_st_addr  (o_st_addr),
    .o_st_data  (o_st_data)
  );

  // EX/WB
  pipe_stage #(.payload_t(wb_t)) u_ex_wb (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_valid (wb_valid), .i_data (wb),
    .o_valid (wr_valid), .o_data (wr)
  );

  assign o_res_valid = wr_valid;  // Only set for non-zero destinations
  assign o_res_reg   = wr.dst;
  assign o_res_data  = wr.data;

endmodule

/* bench/core_checker.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module core_checker (
  input logic               i_clk,
  input logic               i_rst,
  input logic               i_instr_valid,
  input logic [`DATA_W-1:0] i_instr,
  input logic               i_res_valid,
  input logic [`REG_AW-1:0] i_res_reg,
  input logic               i_st_valid
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  logic [5:0]  opcode;
  logic        known_op;

  assign opcode   = i_instr[31:26];
  assign known_op = (opcode == `OP_RTYPE) || (opcode == `OP_ADDI) || (opcode == `OP_ADDIU) ||
                    (opcode == `OP_SLTI) || (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                    (opcode == `OP_XORI) || (opcode[5:4] == 2'b10);  // Loads and stores

  // r0 is never reported
  a_res_not_r0: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_valid |-> (i_res_reg != '0))
    else begin fail_cnt++; $error("result reported for register 0"); end

  // Quiet outputs in reset, once the pipe has cleared
  a_quiet_in_reset: assert property (@(posedge i_clk)
    (i_rst && $past(i_rst)) |-> (!i_res_valid && !i_st_valid))
    else begin fail_cnt++; $error("output valid while in reset"); end

  a_store_next: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_instr_valid && opcode[5:3] == 3'b101) |=> i_st_valid)
    else begin fail_cnt++; $error("store strobe not followed by store report"); end

  a_unknown_silent: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_instr_valid && !known_op) |-> ##2 !i_res_valid)
    else begin fail_cnt++; $error("unknown opcode produced a result"); end

endmodule

bind mips_core core_checker u_checker (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_instr_valid (i_instr_valid),
  .i_instr       (i_instr),
  .i_res_valid   (o_res_valid),
  .i_res_reg     (o_res_reg),
  .i_st_valid    (o_st_valid)
);

/* bench/res_monitor.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module res_monitor (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_exp_valid,  // One per driven instruction
  input  logic [1:0]         i_exp_kind,
  input  logic [`DATA_W-1:0] i_exp_idx,
  input  logic [`DATA_W-1:0] i_exp_val,
  input  logic               i_res_valid,
  input  logic [`REG_AW-1:0] i_res_reg,
  input  logic [`DATA_W-1:0] i_res_data,
  input  logic               i_st_valid,
  input  logic [`DATA_W-1:0] i_st_addr,
  input  logic [`DATA_W-1:0] i_st_data,
  input  logic               i_done,       // End of stimulus, flush check
  output int                 o_val_errs,
  output int                 o_evt_errs
);

  localparam logic [1:0] KIND_REG = 2'd1;
  localparam logic [1:0] KIND_ST  = 2'd2;

  int                 cycle = 0;     // Counts rising edges
  int                 val_errs = 0;
  int                 evt_errs = 0;
  logic               closed = 1'b0;
  logic [`DATA_W-1:0] res_idx_q [$];
  logic [`DATA_W-1:0] res_val_q [$];
  int                 res_due_q [$];
  logic [`DATA_W-1:0] st_addr_q [$];
  logic [`DATA_W-1:0] st_data_q [$];
  int                 st_due_q  [$];

  assign o_val_errs = val_errs;
  assign o_evt_errs = evt_errs;

  // Strobe edge: store due this cycle, result one later
  always @(posedge i_clk) begin
    cycle = cycle + 1;
    if (!i_rst && i_exp_valid) begin
      if (i_exp_kind == KIND_REG) begin
        res_idx_q.push_back(i_exp_idx);
        res_val_q.push_back(i_exp_val);
        res_due_q.push_back(cycle + 1);
      end else if (i_exp_kind == KIND_ST) begin
        st_addr_q.push_back(i_exp_idx);
        st_data_q.push_back(i_exp_val);
        st_due_q.push_back(cycle);
      end
    end
    // Leftover expectations once stimulus is done
    if (i_done && !closed) begin
      closed = 1'b1;
      if (res_idx_q.size() != 0 || st_addr_q.size() != 0) begin
        $display("%0d expected register writes and %0d expected stores never arrived",
                 res_idx_q.size(), st_addr_q.size());
        evt_errs = evt_errs + res_idx_q.size() + st_addr_q.size();
      end
    end
  end

  task automatic check_result();
    logic [`DATA_W-1:0] idx;
    logic [`DATA_W-1:0] val;
    int                 due;
    if (res_idx_q.size() == 0) begin
      $display("Register write to r%0d at %0t arrived with nothing expected", i_res_reg, $time);
      evt_errs++;
    end else begin
      idx = res_idx_q.pop_front();
      val = res_val_q.pop_front();
      due = res_due_q.pop_front();
      if (i_res_reg != idx[`REG_AW-1:0] || i_res_data != val) begin
        $display("ERR %0t: result r%0d = %08h, expected r%0d = %08h",
                 $time, i_res_reg, i_res_data, idx, val);
        val_errs++;
      end
      if (cycle != due) begin
        $display("ERR %0t: result r%0d in cycle %0d, expected cycle %0d",
                 $time, i_res_reg, cycle, due);
        val_errs++;
      end
    end
  endtask

  task automatic check_store();
    logic [`DATA_W-1:0] addr;
    logic [`DATA_W-1:0] data;
    int                 due;
    if (st_addr_q.size() == 0) begin
      $display("Store to %08h at %0t arrived with nothing expected", i_st_addr, $time);
      evt_errs++;
    end else begin
      addr = st_addr_q.pop_front();
      data = st_data_q.pop_front();
      due  = st_due_q.pop_front();
      if (i_st_addr != addr || i_st_data != data) begin
        $display("ERR %0t: store [%08h] = %08h, expected [%08h] = %08h",
                 $time, i_st_addr, i_st_data, addr, data);
        val_errs++;
      end
      if (cycle != due) begin
        $display("ERR %0t: store in cycle %0d, expected cycle %0d", $time, cycle, due);
        val_errs++;
      end
    end
  endtask

  // Falling edge, outputs settled
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (i_res_valid) check_result();
      if (i_st_valid) check_store();
    end
  end

endmodule

/* bench/tb_mips_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_mips_core;

  localparam int MAX_TESTS  = 64;
  localparam int RST_CYCLES = 16;

  logic               clk;
  logic               rst;
  logic               instr_valid;
  logic [`DATA_W-1:0] instr;
  logic               res_valid;
  logic [`REG_AW-1:0] res_reg;
  logic [`DATA_W-1:0] res_data;
  logic               st_valid;
  logic [`DATA_W-1:0] st_addr;
  logic [`DATA_W-1:0] st_data;
  logic               exp_valid;
  logic [1:0]         exp_kind;
  logic [`DATA_W-1:0] exp_idx;
  logic [`DATA_W-1:0] exp_val;
  logic               done;
  int                 val_errs;
  int                 evt_errs;
  logic [31:0]        tests [4*MAX_TESTS];  // Four words per test
  int                 n_tests;
  int                 wd_cycles;
  int                 seed;
  int                 idle;
  int                 total;

  mips_core i_mips_core (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .o_res_valid   (res_valid),
    .o_res_reg     (res_reg),
    .o_res_data    (res_data),
    .o_st_valid    (st_valid),
    .o_st_addr     (st_addr),
    .o_st_data     (st_data)
  );

  res_monitor i_monitor (
    .i_clk (clk), .i_rst (rst),
    .i_exp_valid (exp_valid), .i_exp_kind (exp_kind),
    .i_exp_idx (exp_idx), .i_exp_val (exp_val),
    .i_res_valid (res_valid), .i_res_reg (res_reg), .i_res_data (res_data),
    .i_st_valid (st_valid), .i_st_addr (st_addr), .i_st_data (st_data),
    .i_done (done), .o_val_errs (val_errs), .o_evt_errs (evt_errs)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Tests end at the kind 3 marker
  function automatic int count_tests();
    int n;
    n = 0;
    while (n < MAX_TESTS && tests[4*n+1] != 32'h3) n++;
    return n;
  endfunction

  task automatic apply_test(input int t);
    instr_valid = 1'b1;
    instr       = tests[4*t];
    exp_valid   = 1'b1;  // Expected event travels with the strobe
    exp_kind    = tests[4*t+1][1:0];
    exp_idx     = tests[4*t+2];
    exp_val     = tests[4*t+3];
  endtask

  initial begin
    clk = 1'b0; rst = 1'b1;
    instr_valid = 1'b0; instr = '0;
    exp_valid = 1'b0; exp_kind = '0; exp_idx = '0; exp_val = '0;
    done = 1'b0;
    seed = 32'hd6c13aa3;
    $readmemh("bench/core_tests.mem", tests);
    n_tests   = count_tests();
    wd_cycles = n_tests * 6 + RST_CYCLES + 40;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Random gaps first, then back to back so close pairs hit the bypass
    for (int pass = 0; pass < 2; pass++) begin
      for (int t = 0; t < n_tests; t++) begin
        apply_test(t);
        @(negedge clk);
        instr_valid = 1'b0;
        exp_valid   = 1'b0;
        idle = (pass == 0) ? ($random(seed) & 32'h3) : 0;  // 0 to 3 idle cycles
        repeat (idle) @(negedge clk);
      end
    end
    repeat (4) @(negedge clk);  // Drain the pipe
    done = 1'b1;
    @(negedge clk);
    total = val_errs + evt_errs + i_mips_core.u_checker.fail_cnt;
    $display("Errors: %0d value, %0d event, %0d assertion",
             val_errs, evt_errs, i_mips_core.u_checker.fail_cnt);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog, sized after the test count is known
  initial begin
    #1;
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", wd_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* bench/core_tests.mem */
// Columns: instruction, kind (0 none, 1 register write, 2 store, 3 end of list),
// register index or store address, expected value
20010005 1 00000001 00000005  // addi r1, r0, 5
2002fffd 1 00000002 fffffffd  // addi r2, r0, -3
20037fff 1 00000003 00007fff  // addi r3, r0, 0x7fff
00222020 1 00000004 00000002  // add r4, r1, r2
00412822 1 00000005 fffffff8  // sub r5, r2, r1
00433024 1 00000006 00007ffd  // and r6, r2, r3
00223825 1 00000007 fffffffd  // or r7, r1, r2
00234026 1 00000008 00007ffa  // xor r8, r1, r3
00224827 1 00000009 00000002  // nor r9, r1, r2
0041502a 1 0000000a 00000001  // slt r10, r2, r1, signed true
0022582a 1 0000000b 00000000  // slt r11, r1, r2
00a26021 1 0000000c fffffff5  // addu r12, r5, r2, carry out dropped
00016822 1 0000000d fffffffb  // sub r13, r0, r1
242efff0 1 0000000e fffffff5  // addiu r14, r1, -16
284ffffe 1 0000000f 00000001  // slti r15, r2, -2
28308000 1 00000010 00000000  // slti r16, r1, -32768
3051f0f0 1 00000011 0000f0f0  // andi r17, r2, 0xf0f0, zero-extended
34328000 1 00000012 00008005  // ori r18, r1, 0x8000
3853ffff 1 00000013 ffff0002  // xori r19, r2, 0xffff
20140040 1 00000014 00000040  // addi r20, r0, 0x40, store base
ac050010 2 00000010 fffffff8  // sw r5, 0x10(r0)
a288fff8 2 00000038 00007ffa  // 101000 store r8, -8(r20)
8c150010 1 00000015 fffffff8  // lw r21, 0x10(r0)
8296fff8 1 00000016 00007ffa  // 100000 load r22, -8(r20)
8c170004 1 00000017 00000000  // lw r23, 4(r0), never written
20200123 0 00000000 00000000  // addi r0, r1, 0x123, dropped
00220020 0 00000000 00000000  // add r0, r1, r2, dropped
fc221234 0 00000000 00000000  // Opcode 111111
08000010 0 00000000 00000000  // Opcode 000010, jump not supported
40a10000 0 00000000 00000000  // Opcode 010000
20180000 1 00000018 00000000  // addi r24, r0, 0
0000c820 1 00000019 00000000  // add r25, r0, r0
0001d025 1 0000001a 00000005  // or r26, r0, r1
201b0011 1 0000001b 00000011  // addi r27, r0, 0x11
201c0022 1 0000001c 00000022  // addi r28, r0, 0x22
237d0001 1 0000001d 00000012  // addi r29, r27, 1, two strobes after r27
239e0002 1 0000001e 00000024  // addi r30, r28, 2
4c000000 0 00000000 00000000  // Opcode 010011 as a spacer
03bef822 1 0000001f ffffffee  // sub r31, r29, r30
00000000 3 00000000 00000000  // End of list

/* all.f */
+incdir+logic
logic/core_pkg.sv
logic/main_control.sv
logic/decode_stage.sv
logic/pipe_stage.sv
logic/exec_stage.sv
logic/mips_core.sv
bench/core_checker.sv
bench/res_monitor.sv
bench/tb_mips_core.sv
